//--- agen_defs.svh
// Sizing macros for the address-generation subsystem, included by every file that sizes logic
`ifndef AGEN_DEFS_SVH
`define AGEN_DEFS_SVH

// Width of virtual and physical addresses
`define AGEN_ADDR_W 32

// Offset bits inside one cache line, so a line is 64 bytes
`define AGEN_LINE_BITS 6

// Offset bits inside one page, so a page is 4 KiB
`define AGEN_PAGE_BITS 12

// Entries in the direct-mapped translation table
`define AGEN_TLB_ENTRIES 8

// Depth of each per-port buffer in the arbiter
// This is also the number of credits a port starts with
`define AGEN_PORT_CREDITS 2

// Requests the memory side can hold before it must return a credit
`define AGEN_MEM_CREDITS 4

// Width of the micro-op tag carried through to memory
`define AGEN_TAG_W 4

`endif

//--- isa_pkg.sv
// Instruction-side types for the address generators, imported where ops are decoded
package isa_pkg;

	// ========================================
	// Instruction word
	// ========================================

	// Bit 31 picks the format and sits at the same place in both views
	localparam logic FMT_INDEXED = 1'b0;
	localparam logic FMT_DISP    = 1'b1;

	// Indexed form computes base + (index << scale) + disp
	typedef struct packed {
		logic               fmt;
		logic [1:0]         scale;
		// Register specifier bits, already consumed by the operand read
		logic [4:0]         rsvd_reg;
		logic signed [11:0] disp;
		logic [11:0]        rsvd_lo;
	} insn_indexed_t;

	// Displacement form computes base + disp with a wide offset
	typedef struct packed {
		logic               fmt;
		logic signed [30:0] disp;
	} insn_disp_t;

	// One 32-bit word seen through either view
	typedef union packed {
		insn_indexed_t indexed;
		insn_disp_t    disp;
	} agen_insn_u;

	// ========================================
	// Access kind
	// ========================================

	// Atomics address memory with the base operand alone
	typedef enum logic [1:0] {
		ACC_LOAD  = 2'd0,
		ACC_STORE = 2'd1,
		ACC_AMO   = 2'd2,
		ACC_V2P   = 2'd3
	} access_kind_e;

endpackage

//--- mem_pkg.sv
// Memory-side types shared by the generators, the arbiter and the translator
`include "agen_defs.svh"

package mem_pkg;

	// Virtual or physical byte address
	typedef logic [`AGEN_ADDR_W-1:0] addr_t;

	// Tag that follows an op all the way to the memory port
	typedef logic [`AGEN_TAG_W-1:0] tag_t;

	// ========================================
	// Issue side
	// ========================================

	// Memory micro-op with operands already read from the register file
	typedef struct packed {
		isa_pkg::agen_insn_u   insn;
		addr_t                 base;
		addr_t                 index;
		isa_pkg::access_kind_e kind;
		// Ask for the start of the following cache line instead
		logic                  next_line;
		tag_t                  tag;
	} agen_op_t;

	// ========================================
	// Request side
	// ========================================

	// Effective virtual address leaving a generator port
	typedef struct packed {
		addr_t                 vaddr;
		isa_pkg::access_kind_e kind;
		tag_t                  tag;
	} vreq_t;

	// Translated request presented to the memory port
	typedef struct packed {
		addr_t                 paddr;
		isa_pkg::access_kind_e kind;
		tag_t                  tag;
		// Generator port the request came from
		logic                  port;
		// Set when translation found no valid entry
		logic                  fault;
	} preq_t;

endpackage

//--- agen_unit.sv
// One address-generation port, instantiated once per load/store pipe under agen_top
`timescale 1ns/1ps
`include "agen_defs.svh"

module agen_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              op_valid,
	input  mem_pkg::agen_op_t op,
	output logic              op_ready,
	output logic              req_valid,
	output mem_pkg::vreq_t    req,
	input  logic              credit_return
);
	import isa_pkg::*;
	import mem_pkg::*;

	// Enough bits to count from zero up to a full set of credits
	localparam int CNT_W = $clog2(`AGEN_PORT_CREDITS + 1);

	agen_insn_u       insn;
	addr_t            disp_ext;
	addr_t            index_scaled;
	addr_t            ea;
	addr_t            ea_line;
	logic             stage_valid;
	logic             send;
	logic             accept;
	logic [CNT_W-1:0] credit_cnt;

	// ========================================
	// Address computation
	// ========================================

	// The word is decoded straight off the incoming op
	always_comb begin
		insn         = op.insn;
		index_scaled = op.index << insn.indexed.scale;
		// Each view sign-extends its own displacement field
		unique case (insn.disp.fmt)
			FMT_DISP: begin
				disp_ext = {{(`AGEN_ADDR_W-31){insn.disp.disp[30]}}, insn.disp.disp};
			end
			FMT_INDEXED: begin
				disp_ext = {{(`AGEN_ADDR_W-12){insn.indexed.disp[11]}}, insn.indexed.disp};
			end
		endcase
		// Atomics ignore both index and displacement
		if (op.kind == ACC_AMO)
			ea = op.base;
		else if (insn.disp.fmt == FMT_DISP)
			ea = op.base + disp_ext;
		else
			ea = op.base + index_scaled + disp_ext;
	end

	// Next-line requests drop the line offset and step one line forward
	always_comb begin
		if (op.next_line)
			ea_line = {ea[`AGEN_ADDR_W-1:`AGEN_LINE_BITS] + 1'b1, {`AGEN_LINE_BITS{1'b0}}};
		else
			ea_line = ea;
	end

	// ========================================
	// Result stage and handshakes
	// ========================================

	// A held result goes out only with a credit in hand, and never while flushed
	assign send      = stage_valid && (credit_cnt != '0) && !flush;
	assign req_valid = send;

	// The stage takes a new op when empty or when the old one leaves this cycle
	assign op_ready = !stage_valid || send;
	assign accept   = op_valid && op_ready;

	// The result payload is captured on the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			req.vaddr <= ea_line;
			req.kind  <= op.kind;
			req.tag   <= op.tag;
		end
	end

	// Sticky valid holds until the result is sent or the port is flushed
	always_ff @(posedge clk) begin
		if (rst)
			stage_valid <= 1'b0;
		else if (accept)
			stage_valid <= 1'b1;
		else if (send || flush)
			stage_valid <= 1'b0;
	end

	// One credit per free slot in this port's arbiter buffer
	always_ff @(posedge clk) begin
		if (rst)
			credit_cnt <= CNT_W'(`AGEN_PORT_CREDITS);
		else
			credit_cnt <= credit_cnt - CNT_W'(send) + CNT_W'(credit_return);
	end

	// The arbiter returns no more credits than this port has spent
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= CNT_W'(`AGEN_PORT_CREDITS))
		else $error("agen_unit credit count above buffer depth");

	// A credit comes back only while this port has a request sitting in the arbiter
	a_credit_owed: assert property (@(posedge clk) disable iff (rst)
		credit_return |-> (credit_cnt != CNT_W'(`AGEN_PORT_CREDITS)))
		else $error("agen_unit credit returned with none outstanding");

endmodule

//--- addr_arbiter.sv
// Round-robin arbiter that merges both generator ports onto the single translation path
`timescale 1ns/1ps
`include "agen_defs.svh"

module addr_arbiter (
	input  logic           clk,
	input  logic           rst,
	input  logic [1:0]     req_valid,
	input  mem_pkg::vreq_t req [2],
	output logic [1:0]     credit_return,
	output logic           sel_valid,
	output mem_pkg::vreq_t sel,
	output logic           port_id,
	input  logic           mem_credit
);
	import mem_pkg::*;

	// Buffer pointers wrap on their own since the depth is a power of two
	localparam int DEPTH     = `AGEN_PORT_CREDITS;
	localparam int PTR_W     = $clog2(DEPTH);
	localparam int CNT_W     = $clog2(DEPTH + 1);
	localparam int MEM_CNT_W = $clog2(`AGEN_MEM_CREDITS + 1);

	vreq_t                fifo_mem [2][DEPTH];
	logic [PTR_W-1:0]     wr_ptr [2];
	logic [PTR_W-1:0]     rd_ptr [2];
	logic [CNT_W-1:0]     fifo_cnt [2];
	logic [1:0]           not_empty;
	logic [1:0]           pop;
	logic                 winner;
	logic                 last_port;
	logic                 grant;
	logic [MEM_CNT_W-1:0] mem_cnt;

	// ========================================
	// Per-port buffers
	// ========================================

	// Payload storage; the port credits guarantee a free slot on every write
	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (req_valid[p])
				fifo_mem[p][wr_ptr[p]] <= req[p];
		end
	end

	// Pointers and occupancy for both buffers
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int p = 0; p < 2; p++) begin
				wr_ptr[p]   <= '0;
				rd_ptr[p]   <= '0;
				fifo_cnt[p] <= '0;
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (req_valid[p])
					wr_ptr[p] <= wr_ptr[p] + 1'b1;
				if (pop[p])
					rd_ptr[p] <= rd_ptr[p] + 1'b1;
				fifo_cnt[p] <= fifo_cnt[p] + CNT_W'(req_valid[p]) - CNT_W'(pop[p]);
			end
		end
	end

	// ========================================
	// Round-robin selection
	// ========================================

	always_comb begin
		for (int p = 0; p < 2; p++)
			not_empty[p] = (fifo_cnt[p] != '0);
		// With both waiting, the port that did not win last time goes first
		if (not_empty[0] && not_empty[1])
			winner = !last_port;
		else
			winner = not_empty[1];
		// Nothing leaves unless the memory side has room for it
		grant  = (|not_empty) && (mem_cnt != '0);
		pop[0] = grant && !winner;
		pop[1] = grant && winner;
	end

	// Each pop frees one buffer slot, so the owning port gets its credit back
	assign credit_return = pop;

	// Reset as if port 1 won last, so port 0 is served first
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_valid <= 1'b0;
			last_port <= 1'b1;
		end else begin
			sel_valid <= grant;
			if (grant)
				last_port <= winner;
		end
	end

	// Selected request and its port, registered toward the translator
	always_ff @(posedge clk) begin
		if (grant) begin
			sel     <= fifo_mem[winner][rd_ptr[winner]];
			port_id <= winner;
		end
	end

	// Downstream credits: spent on each grant, returned as memory retires requests
	always_ff @(posedge clk) begin
		if (rst)
			mem_cnt <= MEM_CNT_W'(`AGEN_MEM_CREDITS);
		else
			mem_cnt <= mem_cnt - MEM_CNT_W'(grant) + MEM_CNT_W'(mem_credit);
	end

	// A generator only writes while it holds a credit for a free slot
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(req_valid[0] && fifo_cnt[0] == CNT_W'(DEPTH)) &&
		!(req_valid[1] && fifo_cnt[1] == CNT_W'(DEPTH)))
		else $error("addr_arbiter buffer written while full");

	// Memory never returns more credits than were handed out
	a_mem_credit_range: assert property (@(posedge clk) disable iff (rst)
		mem_cnt <= MEM_CNT_W'(`AGEN_MEM_CREDITS))
		else $error("addr_arbiter memory credit count out of range");

endmodule

//--- page_translate.sv
// Direct-mapped page translation between the arbiter and the memory port of agen_top
`timescale 1ns/1ps
`include "agen_defs.svh"

module page_translate (
	input  logic           clk,
	input  logic           rst,
	input  logic           xlate_en,
	input  logic           fill_valid,
	input  mem_pkg::addr_t fill_vpn,
	input  mem_pkg::addr_t fill_ppn,
	input  logic           sel_valid,
	input  mem_pkg::vreq_t sel,
	input  logic           port_id,
	output logic           mem_req_valid,
	output mem_pkg::preq_t mem_req
);
	import mem_pkg::*;

	// Page numbers are the address bits above the page offset
	localparam int VPN_W = `AGEN_ADDR_W - `AGEN_PAGE_BITS;
	localparam int IDX_W = $clog2(`AGEN_TLB_ENTRIES);
	localparam int TAG_W = VPN_W - IDX_W;

	logic [`AGEN_TLB_ENTRIES-1:0] tlb_valid;
	logic [TAG_W-1:0]             tlb_tag [`AGEN_TLB_ENTRIES];
	logic [VPN_W-1:0]             tlb_ppn [`AGEN_TLB_ENTRIES];
	logic [VPN_W-1:0]             fill_vpn_w;
	logic [IDX_W-1:0]             fill_idx;
	logic [VPN_W-1:0]             lk_vpn;
	logic [IDX_W-1:0]             lk_idx;
	logic                         lk_hit;
	preq_t                        xreq;

	// ========================================
	// Table fill
	// ========================================

	// The fill port carries page numbers right-aligned in an address word
	assign fill_vpn_w = fill_vpn[VPN_W-1:0];
	assign fill_idx   = fill_vpn_w[IDX_W-1:0];

	// Entry valid bits are the only state that needs clearing
	always_ff @(posedge clk) begin
		if (rst)
			tlb_valid <= '0;
		else if (fill_valid)
			tlb_valid[fill_idx] <= 1'b1;
	end

	// A fill overwrites whatever mapping shared the same low page bits
	always_ff @(posedge clk) begin
		if (fill_valid) begin
			tlb_tag[fill_idx] <= fill_vpn_w[VPN_W-1:IDX_W];
			tlb_ppn[fill_idx] <= fill_ppn[VPN_W-1:0];
		end
	end

	// ========================================
	// Lookup
	// ========================================

	always_comb begin
		lk_vpn = sel.vaddr[`AGEN_ADDR_W-1:`AGEN_PAGE_BITS];
		lk_idx = lk_vpn[IDX_W-1:0];
		lk_hit = tlb_valid[lk_idx] && (tlb_tag[lk_idx] == lk_vpn[VPN_W-1:IDX_W]);
		xreq.kind = sel.kind;
		xreq.tag  = sel.tag;
		xreq.port = port_id;
		if (!xlate_en) begin
			// Translation off passes the address through untouched
			xreq.paddr = sel.vaddr;
			xreq.fault = 1'b0;
		end else if (lk_hit) begin
			xreq.paddr = {tlb_ppn[lk_idx], sel.vaddr[`AGEN_PAGE_BITS-1:0]};
			xreq.fault = 1'b0;
		end else begin
			// No table walk here, the miss goes out flagged
			xreq.paddr = '0;
			xreq.fault = 1'b1;
		end
	end

	// One register stage toward the memory port
	always_ff @(posedge clk) begin
		if (rst)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= sel_valid;
	end

	always_ff @(posedge clk) begin
		if (sel_valid)
			mem_req <= xreq;
	end

endmodule

//--- agen_top.sv
// Top of the dual-port address-generation subsystem, seen by the load/store pipeline
`timescale 1ns/1ps

module agen_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              xlate_en,
	input  logic [1:0]        flush,
	input  logic [1:0]        op_valid,
	input  mem_pkg::agen_op_t op [2],
	output logic [1:0]        op_ready,
	input  logic              fill_valid,
	input  mem_pkg::addr_t    fill_vpn,
	input  mem_pkg::addr_t    fill_ppn,
	output logic              mem_req_valid,
	output mem_pkg::preq_t    mem_req,
	input  logic              mem_credit
);
	import mem_pkg::*;

	// Generator to arbiter links
	logic [1:0] req_valid;
	vreq_t      req [2];
	logic [1:0] credit_return;

	// Arbiter to translator link
	logic       sel_valid;
	vreq_t      sel;
	logic       port_id;

	// ========================================
	// Generator ports
	// ========================================

	agen_unit u_agen0 (
		.clk(clk), .rst(rst), .flush(flush[0]),
		.op_valid(op_valid[0]), .op(op[0]), .op_ready(op_ready[0]),
		.req_valid(req_valid[0]), .req(req[0]), .credit_return(credit_return[0])
	);

	agen_unit u_agen1 (
		.clk(clk), .rst(rst), .flush(flush[1]),
		.op_valid(op_valid[1]), .op(op[1]), .op_ready(op_ready[1]),
		.req_valid(req_valid[1]), .req(req[1]), .credit_return(credit_return[1])
	);

	// ========================================
	// Shared path to memory
	// ========================================

	addr_arbiter u_arb (
		.clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
		.credit_return(credit_return), .sel_valid(sel_valid), .sel(sel),
		.port_id(port_id), .mem_credit(mem_credit)
	);

	// The translator always accepts, the arbiter's memory credits cover its output
	page_translate u_xlate (
		.clk(clk), .rst(rst), .xlate_en(xlate_en),
		.fill_valid(fill_valid), .fill_vpn(fill_vpn), .fill_ppn(fill_ppn),
		.sel_valid(sel_valid), .sel(sel), .port_id(port_id),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req)
	);

endmodule

//--- tb_agen_top.sv
// Directed testbench for agen_top, run as the simulation top with the DUT and a memory model
`timescale 1ns/1ps
`include "agen_defs.svh"

module tb_agen_top;
	import isa_pkg::*;
	import mem_pkg::*;

	// Longest any single wait loop may run in clock cycles
	localparam int TIMEOUT = 200;

	logic       clk;
	logic       rst;
	logic       xlate_en;
	logic [1:0] flush;
	logic [1:0] op_valid;
	agen_op_t   op [2];
	logic [1:0] op_ready;
	logic       fill_valid;
	addr_t      fill_vpn;
	addr_t      fill_ppn;
	logic       mem_req_valid;
	preq_t      mem_req;
	logic       mem_credit;

	// Memory model state and expected traffic per port
	bit    hold_credits;
	int    credit_delay;
	int    cycle;
	int    rx_count;
	int    seed;
	int    pend_q [$];
	preq_t exp0_q [$];
	preq_t exp1_q [$];
	bit    port_log [$];

	agen_top u_dut (
		.clk(clk), .rst(rst), .xlate_en(xlate_en), .flush(flush),
		.op_valid(op_valid), .op(op), .op_ready(op_ready),
		.fill_valid(fill_valid), .fill_vpn(fill_vpn), .fill_ppn(fill_ppn),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_credit(mem_credit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Failure reporting and checks
	// ========================================

	task automatic stop_failed();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_failed();
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
			stop_failed();
		end
	endtask

	// ========================================
	// Reference address model
	// ========================================

	// Bit 31 of the raw instruction word selects displacement or indexed form
	function automatic addr_t ref_addr(input agen_op_t o);
		logic [31:0] w;
		addr_t       ea;
		w = o.insn;
		if (o.kind == ACC_AMO)
			ea = o.base;
		else if (w[31])
			ea = o.base + {w[30], w[30:0]};
		else
			ea = o.base + (o.index << w[30:29]) + {{20{w[23]}}, w[23:12]};
		// Start of the following cache line
		if (o.next_line)
			ea = ((ea >> `AGEN_LINE_BITS) + 1) << `AGEN_LINE_BITS;
		return ea;
	endfunction

	// Expected request with translation off
	function automatic preq_t expect_plain(input agen_op_t o, input int p);
		preq_t e;
		e.paddr = ref_addr(o);
		e.kind  = o.kind;
		e.tag   = o.tag;
		e.port  = p[0];
		e.fault = 1'b0;
		return e;
	endfunction

	// Form 0 is an atomic, 1 the displacement view and 2 the indexed view
	function automatic agen_op_t build_op(input int form, input bit nl);
		agen_op_t    o;
		logic [31:0] w;
		logic [1:0]  k;
		w = $random(seed);
		k = $random(seed);
		if (form == 1)
			w[31] = 1'b1;
		else if (form == 2)
			w[31] = 1'b0;
		o.insn      = w;
		o.base      = $random(seed);
		o.index     = $random(seed);
		o.kind      = (form == 0) ? ACC_AMO : ((k == 2'd2) ? ACC_LOAD : access_kind_e'(k));
		o.next_line = nl;
		o.tag       = $random(seed);
		return o;
	endfunction

	// ========================================
	// Memory model
	// ========================================

	// Records each request and schedules its credit; retires credits it has handed out
	always @(posedge clk) begin
		preq_t e;
		cycle = cycle + 1;
		if (mem_credit)
			void'(pend_q.pop_front());
		if (!rst && mem_req_valid) begin
			rx_count = rx_count + 1;
			port_log.push_back(mem_req.port);
			pend_q.push_back(cycle + credit_delay);
			if ((mem_req.port ? exp1_q.size() : exp0_q.size()) == 0) begin
				abort_run($sformatf("Unexpected request from port %0d at time %0t",
					mem_req.port, $time));
			end else begin
				e = mem_req.port ? exp1_q.pop_front() : exp0_q.pop_front();
				check_eq(mem_req.paddr, e.paddr, "paddr");
				check_eq(mem_req.kind, e.kind, "kind");
				check_eq(mem_req.tag, e.tag, "tag");
				check_eq(mem_req.fault, e.fault, "fault");
			end
		end
	end

	// One credit at most per cycle once its delay is over and credits are not held
	always @(negedge clk) begin
		mem_credit = !hold_credits && (pend_q.size() > 0) && (pend_q[0] <= cycle);
	end

	// ========================================
	// Stimulus helpers entered and left on a falling edge
	// ========================================

	task automatic send_op(input int p, input agen_op_t o, input preq_t e, input bit expect_out);
		int waited;
		bit accepted;
		waited   = 0;
		accepted = 1'b0;
		op[p]       = o;
		op_valid[p] = 1'b1;
		while (!accepted) begin
			@(posedge clk);
			accepted = op_ready[p];
			waited++;
			if (!accepted && waited > TIMEOUT)
				abort_run($sformatf("Timed out waiting for port %0d to accept an op", p));
		end
		if (expect_out && p == 0)
			exp0_q.push_back(e);
		else if (expect_out)
			exp1_q.push_back(e);
		@(negedge clk);
		op_valid[p] = 1'b0;
	endtask

	task automatic wait_count(input int target, input string what);
		int waited;
		waited = 0;
		while (rx_count < target) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT)
				abort_run($sformatf("Timed out waiting for %s", what));
		end
	endtask

	// Waits until every expected request arrived and every credit went back
	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (exp0_q.size() != 0 || exp1_q.size() != 0 || pend_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT)
				abort_run("Timed out waiting for outstanding requests to drain");
		end
	endtask

	task automatic fill_entry(input addr_t vpn, input addr_t ppn);
		fill_valid = 1'b1;
		fill_vpn   = vpn;
		fill_ppn   = ppn;
		@(negedge clk);
		fill_valid = 1'b0;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_addr_forms();
		agen_op_t o;
		for (int i = 0; i < 12; i++) begin
			o = build_op(i % 3, 1'b0);
			send_op(0, o, expect_plain(o, 0), 1'b1);
		end
		wait_drain();
	endtask

	task automatic test_next_line();
		agen_op_t o;
		// A slower memory keeps several requests in flight at once
		credit_delay = 7;
		for (int i = 0; i < 6; i++) begin
			o = build_op(i % 3, 1'b1);
			send_op(0, o, expect_plain(o, 0), 1'b1);
		end
		wait_drain();
		credit_delay = 2;
	endtask

	task automatic test_translate();
		addr_t    vpns [4];
		agen_op_t o;
		preq_t    e;
		logic     [11:0] off;
		// Two mapped pages, one empty slot and one page aliasing a mapped slot
		vpns = '{32'h12, 32'habcd, 32'h33, 32'h1012};
		fill_entry(32'h12, 32'h345);
		fill_entry(32'habcd, 32'h777);
		xlate_en = 1'b1;
		for (int i = 0; i < 8; i++) begin
			o   = build_op(1, 1'b0);
			off = $random(seed);
			o.insn = {1'b1, 19'd0, off};
			o.base = vpns[i % 4] << `AGEN_PAGE_BITS;
			e = expect_plain(o, 0);
			if (i % 4 < 2) begin
				e.paddr = {((i % 4 == 0) ? 20'h345 : 20'h777), off};
			end else begin
				e.paddr = '0;
				e.fault = 1'b1;
			end
			send_op(0, o, e, 1'b1);
		end
		wait_drain();
		xlate_en = 1'b0;
	endtask

	task automatic test_arbitration();
		agen_op_t ops0 [6];
		agen_op_t ops1 [6];
		for (int i = 0; i < 6; i++) begin
			ops0[i] = build_op(i % 3, 1'b0);
			ops1[i] = build_op((i + 1) % 3, 1'b0);
		end
		port_log.delete();
		fork
			for (int i = 0; i < 6; i++)
				send_op(0, ops0[i], expect_plain(ops0[i], 0), 1'b1);
			for (int i = 0; i < 6; i++)
				send_op(1, ops1[i], expect_plain(ops1[i], 1), 1'b1);
		join
		wait_drain();
		// The tail may serve one port twice once the other buffer runs dry
		for (int i = 1; i < 10; i++)
			check_eq(port_log[i] != port_log[i-1], 1'b1, "round-robin alternation");
	endtask

	task automatic test_backpressure();
		agen_op_t ops [8];
		int       base;
		int       waited;
		for (int i = 0; i < 8; i++)
			ops[i] = build_op(i % 3, i[2]);
		base = rx_count;
		hold_credits = 1'b1;
		fork
			for (int i = 0; i < 8; i++)
				send_op(0, ops[i], expect_plain(ops[i], 0), 1'b1);
			begin
				wait_count(base + `AGEN_MEM_CREDITS, "requests before the credit stall");
				waited = 0;
				while (op_ready[0]) begin
					@(posedge clk);
					waited++;
					if (waited > TIMEOUT)
						abort_run("Timed out waiting for op_ready to fall under back-pressure");
				end
				repeat (4) @(negedge clk);
				check_eq(rx_count - base, `AGEN_MEM_CREDITS, "requests issued without credits");
				hold_credits = 1'b0;
			end
		join
		wait_drain();
	endtask

	task automatic test_flush();
		agen_op_t o;
		int       base;
		base = rx_count;
		hold_credits = 1'b1;
		for (int i = 0; i < `AGEN_MEM_CREDITS; i++) begin
			o = build_op(i % 3, 1'b0);
			send_op(0, o, expect_plain(o, 0), 1'b1);
		end
		wait_count(base + `AGEN_MEM_CREDITS, "memory credits to run out")
;
		@(negedge clk);
		// The dropped op must never reach memory, so nothing is expected for it
		o = build_op(2, 1'b0);
		send_op(1, o, expect_plain(o, 1), 1'b0);
		flush[1] = 1'b1;
		@(negedge clk);
		flush[1] = 1'b0;
		// Memory is still stalled here
		// Port 1 fills its buffer and then holds one more op in its stage only
		// when the flush left every credit in place
		for (int i = 0; i < `AGEN_PORT_CREDITS + 1; i++) begin
			o = build_op(i % 3, 1'b0);
			send_op(1, o, expect_plain(o, 1), 1'b1);
		end
		check_eq(op_ready[1], 1'b0, "port 1 ready with its buffer and stage full");
		hold_credits = 1'b0;
		wait_drain();
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		seed         = 32'h503d;
		rst          = 1'b1;
		xlate_en     = 1'b0;
		flush        = '0;
		op_valid     = '0;
		op[0]        = '0;
		op[1]        = '0;
		fill_valid   = 1'b0;
		fill_vpn     = '0;
		fill_ppn     = '0;
		mem_credit   = 1'b0;
		hold_credits = 1'b0;
		credit_delay = 2;
		cycle        = 0;
		rx_count     = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_eq(op_ready, 2'b11, "op_ready after reset");
		check_eq(mem_req_valid, 1'b0, "mem_req_valid after reset");
		test_addr_forms();
		test_next_line();
		test_translate();
		test_arbitration();
		test_backpressure();
		test_flush();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- files.f
+incdir+.
isa_pkg.sv
mem_pkg.sv
agen_unit.sv
addr_arbiter.sv
page_translate.sv
agen_top.sv
tb_agen_top.sv
